// ==== include/vag_macros.svh ====
// Vector address generator constants
// Widths, AXI burst limits and the command queue depth

`ifndef VAG_MACROS_SVH
`define VAG_MACROS_SVH

// Address and vector length widths
`define VAG_ADDR_W        32
`define VAG_VL_W          16

// AXI data bus and burst limits
`define VAG_BUS_BYTES     8
`define VAG_BUS_BYTES_LOG 3
`define VAG_MAX_BEATS     256
`define VAG_PAGE_BITS     12

`define VAG_CMD_DEPTH     4

`endif

// ==== source/vag_pkg.sv ====
// Vector address generator types
// Plain vector typedefs for the widths that carry a meaning

`include "vag_macros.svh"

package vag_pkg;

  // Byte address on the AXI bus
  typedef logic [`VAG_ADDR_W-1:0] addr_t;

  // Element count of a vector instruction
  typedef logic [`VAG_VL_W-1:0] vl_t;

  // log2 of the element size in bytes
  typedef logic [1:0] sew_t;

  // AXI burst length, beats minus one
  typedef logic [7:0] axi_len_t;

  // AXI log2 of bytes per beat
  typedef logic [2:0] axi_size_t;

endpackage

// ==== source/lsu_cmd_fifo.sv ====
// Command queue toward the load/store units
// Holds one entry per issued AR or AW request, in issue order

`timescale 1ns/1ns
`include "vag_macros.svh"

module lsu_cmd_fifo (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  vag_pkg::addr_t      addr_i,
  input  vag_pkg::axi_len_t   len_i,
  input  vag_pkg::axi_size_t  size_i,
  input  logic                is_load_i,
  input  logic                pop_i,
  output logic                full_o,
  output logic                empty_o,
  output vag_pkg::addr_t      addr_o,
  output vag_pkg::axi_len_t   len_o,
  output vag_pkg::axi_size_t  size_o,
  output logic                is_load_o
);

  import vag_pkg::*;

  localparam int unsigned ptr_w = $clog2(`VAG_CMD_DEPTH);

  addr_t      addr_mem    [`VAG_CMD_DEPTH];
  axi_len_t   len_mem     [`VAG_CMD_DEPTH];
  axi_size_t  size_mem    [`VAG_CMD_DEPTH];
  logic       is_load_mem [`VAG_CMD_DEPTH];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   count_q;
  logic             do_pop;

  assign full_o  = (count_q == (ptr_w + 1)'(`VAG_CMD_DEPTH));
  assign empty_o = (count_q == '0);
  // A pop on an empty queue has no effect
  assign do_pop  = pop_i && !empty_o;

  assign addr_o    = addr_mem[rd_ptr_q];
  assign len_o     = len_mem[rd_ptr_q];
  assign size_o    = size_mem[rd_ptr_q];
  assign is_load_o = is_load_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q]    <= addr_i;
      len_mem[wr_ptr_q]     <= len_i;
      size_mem[wr_ptr_q]    <= size_i;
      is_load_mem[wr_ptr_q] <= is_load_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (ptr_w + 1)'(push_i) - (ptr_w + 1)'(do_pop);
    end
  end

  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) full_o |-> !push_i
  );

endmodule

// ==== source/unit_stride_planner.sv ====
// Unit-stride burst planner
// Splits a contiguous access into INCR bursts of 8-byte beats that hold
// at most 256 beats and never cross a 4 KiB page

`timescale 1ns/1ns
`include "vag_macros.svh"

module unit_stride_planner (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  vag_pkg::addr_t     addr_i,
  input  vag_pkg::vl_t       vl_i,
  input  vag_pkg::sew_t      sew_i,
  input  logic               step_i,
  output logic               cand_valid_o,
  output vag_pkg::addr_t     cand_addr_o,
  output vag_pkg::axi_len_t  cand_len_o,
  output logic               cand_last_o
);

  import vag_pkg::*;

  localparam addr_t beat_mask  = addr_t'(`VAG_BUS_BYTES - 1);
  localparam addr_t burst_span = addr_t'(`VAG_MAX_BEATS * `VAG_BUS_BYTES);
  localparam addr_t page_mask  = addr_t'((1 << `VAG_PAGE_BITS) - 1);

  logic  valid_q;
  addr_t addr_q;
  vl_t   rem_q;
  sew_t  sew_q;

  addr_t first_beat;
  addr_t data_end;
  addr_t beat_cap_end;
  addr_t page_end;
  addr_t burst_end;
  addr_t beats_m1;
  addr_t consumed;
  vl_t   rem_next;

  ////////////////////
  // Burst limits
  ////////////////////

  always_comb begin
    first_beat   = addr_q & ~beat_mask;
    // Last byte of the remaining data, rounded up to the end of its beat
    data_end     = (addr_q + (addr_t'(rem_q) << sew_q) - 1'b1) | beat_mask;
    beat_cap_end = first_beat + burst_span - 1'b1;
    page_end     = addr_q | page_mask;

    // Earliest of the three end points
    burst_end = data_end;
    if (beat_cap_end < burst_end) begin
      burst_end = beat_cap_end;
    end
    if (page_end < burst_end) begin
      burst_end = page_end;
    end

    beats_m1 = (burst_end - first_beat) >> `VAG_BUS_BYTES_LOG;
    consumed = (burst_end - addr_q + 1'b1) >> sew_q;
    rem_next = (addr_t'(rem_q) > consumed) ? rem_q - vl_t'(consumed) : '0;
  end

  assign cand_valid_o = valid_q;
  assign cand_addr_o  = addr_q;
  assign cand_len_o   = axi_len_t'(beats_m1);
  assign cand_last_o  = (rem_next == '0);

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (start_i) begin
      valid_q <= 1'b1;
    end else if (step_i && cand_last_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= addr_i;
      rem_q  <= vl_i;
      sew_q  <= sew_i;
    end else if (step_i) begin
      // Next burst starts right after this one
      addr_q <= burst_end + 1'b1;
      rem_q  <= rem_next;
    end
  end

  a_len_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cand_valid_o |-> beats_m1 <= addr_t'(`VAG_MAX_BEATS - 1)
  );

endmodule

// ==== source/strided_planner.sv ====
// Strided element walker
// Produces one single-beat request per element, stepping by the stride

`timescale 1ns/1ns

module strided_planner (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  vag_pkg::addr_t      addr_i,
  input  vag_pkg::vl_t        vl_i,
  input  vag_pkg::addr_t      stride_i,
  input  vag_pkg::sew_t       sew_i,
  input  logic                step_i,
  output logic                cand_valid_o,
  output vag_pkg::addr_t      cand_addr_o,
  output vag_pkg::axi_size_t  cand_size_o,
  output logic                cand_last_o
);

  import vag_pkg::*;

  logic  valid_q;
  addr_t addr_q;
  addr_t stride_q;
  sew_t  sew_q;
  vl_t   count_q;

  assign cand_valid_o = valid_q;
  assign cand_addr_o  = addr_q;
  // One element per beat, so the beat size is the element size
  assign cand_size_o  = axi_size_t'(sew_q);
  assign cand_last_o  = (count_q == vl_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (start_i) begin
      valid_q <= 1'b1;
    end else if (step_i && cand_last_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= addr_i;
      stride_q <= stride_i;
      sew_q    <= sew_i;
      count_q  <= vl_i;
    end else if (step_i) begin
      addr_q  <= addr_q + stride_q;
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// ==== source/ax_request_issuer.sv ====
// AX request issuer
// Accepts one instruction at a time, checks the base alignment, drives
// AR or AW from the active planner and keeps the command queue in order

`timescale 1ns/1ns
`include "vag_macros.svh"

module ax_request_issuer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  vag_pkg::addr_t      req_addr_i,
  input  vag_pkg::vl_t        req_vl_i,
  input  vag_pkg::sew_t       req_sew_i,
  input  logic                req_is_load_i,
  input  logic                req_is_unit_i,
  input  logic                unit_valid_i,
  input  vag_pkg::addr_t      unit_addr_i,
  input  vag_pkg::axi_len_t   unit_len_i,
  input  logic                unit_last_i,
  input  logic                str_valid_i,
  input  vag_pkg::addr_t      str_addr_i,
  input  vag_pkg::axi_size_t  str_size_i,
  input  logic                str_last_i,
  input  logic                ar_ready_i,
  input  logic                aw_ready_i,
  input  logic                cmd_pop_i,
  output logic                start_unit_o,
  output logic                start_strided_o,
  output logic                step_unit_o,
  output logic                step_strided_o,
  output logic                ar_valid_o,
  output vag_pkg::addr_t      ar_addr_o,
  output vag_pkg::axi_len_t   ar_len_o,
  output vag_pkg::axi_size_t  ar_size_o,
  output logic                aw_valid_o,
  output vag_pkg::addr_t      aw_addr_o,
  output vag_pkg::axi_len_t   aw_len_o,
  output vag_pkg::axi_size_t  aw_size_o,
  output logic                cmd_valid_o,
  output vag_pkg::addr_t      cmd_addr_o,
  output vag_pkg::axi_len_t   cmd_len_o,
  output vag_pkg::axi_size_t  cmd_size_o,
  output logic                cmd_is_load_o,
  output logic                ack_o,
  output logic                error_o
);

  import vag_pkg::*;

  typedef enum logic [1:0] {
    ISS_IDLE,
    ISS_BUSY,
    ISS_ACK,
    ISS_ERR
  } iss_state_e;

  iss_state_e state_q, state_d;
  logic       is_load_q;
  logic       is_unit_q;

  logic [`VAG_BUS_BYTES_LOG-1:0] align_mask;
  logic      accept, misaligned;
  logic      cand_valid, cand_last, order_ok, issue, handshake;
  addr_t     cand_addr;
  axi_len_t  cand_len;
  axi_size_t cand_size;
  logic      fifo_full, fifo_empty;

  ////////////////////
  // Accept
  ////////////////////

  // Low address bits that must be zero for the element size
  assign align_mask = ~({`VAG_BUS_BYTES_LOG{1'b1}} << req_sew_i);
  assign misaligned = |(req_addr_i[`VAG_BUS_BYTES_LOG-1:0] & align_mask);
  assign accept     = (state_q == ISS_IDLE) && req_valid_i;

  assign start_unit_o    = accept && !misaligned && req_is_unit_i;
  assign start_strided_o = accept && !misaligned && !req_is_unit_i;

  ////////////////////
  // Issue
  ////////////////////

  assign cand_valid = is_unit_q ? unit_valid_i : str_valid_i;
  assign cand_last  = is_unit_q ? unit_last_i : str_last_i;
  assign cand_addr  = is_unit_q ? unit_addr_i : str_addr_i;
  assign cand_len   = is_unit_q ? unit_len_i : '0;
  assign cand_size  = is_unit_q ? axi_size_t'(`VAG_BUS_BYTES_LOG) : str_size_i;

  // Never switch direction while older commands of the other kind wait
  assign order_ok  = fifo_empty || (cmd_is_load_o == is_load_q);
  assign issue     = (state_q == ISS_BUSY) && cand_valid && !fifo_full && order_ok;
  assign handshake = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  assign ar_valid_o = issue && is_load_q;
  assign ar_addr_o  = cand_addr;
  assign ar_len_o   = cand_len;
  assign ar_size_o  = cand_size;
  assign aw_valid_o = issue && !is_load_q;
  assign aw_addr_o  = cand_addr;
  assign aw_len_o   = cand_len;
  assign aw_size_o  = cand_size;

  assign step_unit_o    = handshake && is_unit_q;
  assign step_strided_o = handshake && !is_unit_q;

  assign cmd_valid_o = !fifo_empty;
  assign ack_o       = (state_q == ISS_ACK) || (state_q == ISS_ERR);
  assign error_o     = (state_q == ISS_ERR);

  lsu_cmd_fifo i_lsu_cmd_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_i    (handshake),
    .addr_i    (cand_addr),
    .len_i     (cand_len),
    .size_i    (cand_size),
    .is_load_i (is_load_q),
    .pop_i     (cmd_pop_i),
    .full_o    (fifo_full),
    .empty_o   (fifo_empty),
    .addr_o    (cmd_addr_o),
    .len_o     (cmd_len_o),
    .size_o    (cmd_size_o),
    .is_load_o (cmd_is_load_o)
  );

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ISS_IDLE: begin
        if (accept) begin
          state_d = misaligned ? ISS_ERR : ISS_BUSY;
        end
      end
      ISS_BUSY: begin
        if (handshake && cand_last) begin
          state_d = ISS_ACK;
        end
      end
      // Both acknowledge states last one cycle
      default: state_d = ISS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ISS_IDLE;
      is_load_q <= 1'b0;
      is_unit_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        is_load_q <= req_is_load_i;
        is_unit_q <= req_is_unit_i;
      end
    end
  end

  a_vl_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni) accept |-> req_vl_i != '0
  );

  // A stalled request keeps its valid and its fields until ready
  a_ax_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (ar_valid_o && !ar_ready_i) || (aw_valid_o && !aw_ready_i) |=>
      (ar_valid_o || aw_valid_o) && $stable(cand_addr) && $stable(cand_len)
      && $stable(cand_size)
  );

endmodule

// ==== source/vec_addrgen.sv ====
// Top level of the vector memory address generator
// Turns one vector load or store into AXI AR or AW requests and a
// command queue for the load/store units

`timescale 1ns/1ns

module vec_addrgen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  vag_pkg::addr_t      req_addr_i,
  input  vag_pkg::vl_t        req_vl_i,
  input  vag_pkg::addr_t      req_stride_i,
  input  vag_pkg::sew_t       req_sew_i,
  input  logic                req_is_load_i,
  input  logic                req_is_unit_i,
  input  logic                ar_ready_i,
  input  logic                aw_ready_i,
  input  logic                cmd_pop_i,
  output logic                ar_valid_o,
  output vag_pkg::addr_t      ar_addr_o,
  output vag_pkg::axi_len_t   ar_len_o,
  output vag_pkg::axi_size_t  ar_size_o,
  output logic                aw_valid_o,
  output vag_pkg::addr_t      aw_addr_o,
  output vag_pkg::axi_len_t   aw_len_o,
  output vag_pkg::axi_size_t  aw_size_o,
  output logic                cmd_valid_o,
  output vag_pkg::addr_t      cmd_addr_o,
  output vag_pkg::axi_len_t   cmd_len_o,
  output vag_pkg::axi_size_t  cmd_size_o,
  output logic                cmd_is_load_o,
  output logic                ack_o,
  output logic                error_o
);

  import vag_pkg::*;

  logic      start_unit, start_strided;
  logic      step_unit, step_strided;
  logic      unit_valid, unit_last;
  addr_t     unit_addr;
  axi_len_t  unit_len;
  logic      str_valid, str_last;
  addr_t     str_addr;
  axi_size_t str_size;

  // Burst planner for unit-stride accesses
  unit_stride_planner i_unit_stride_planner (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_unit),
    .addr_i       (req_addr_i),
    .vl_i         (req_vl_i),
    .sew_i        (req_sew_i),
    .step_i       (step_unit),
    .cand_valid_o (unit_valid),
    .cand_addr_o  (unit_addr),
    .cand_len_o   (unit_len),
    .cand_last_o  (unit_last)
  );

  strided_planner i_strided_planner (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_strided),
    .addr_i       (req_addr_i),
    .vl_i         (req_vl_i),
    .stride_i     (req_stride_i),
    .sew_i        (req_sew_i),
    .step_i       (step_strided),
    .cand_valid_o (str_valid),
    .cand_addr_o  (str_addr),
    .cand_size_o  (str_size),
    .cand_last_o  (str_last)
  );

  ax_request_issuer i_ax_request_issuer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_vl_i        (req_vl_i),
    .req_sew_i       (req_sew_i),
    .req_is_load_i   (req_is_load_i),
    .req_is_unit_i   (req_is_unit_i),
    .unit_valid_i    (unit_valid),
    .unit_addr_i     (unit_addr),
    .unit_len_i      (unit_len),
    .unit_last_i     (unit_last),
    .str_valid_i     (str_valid),
    .str_addr_i      (str_addr),
    .str_size_i      (str_size),
    .str_last_i      (str_last),
    .ar_ready_i      (ar_ready_i),
    .aw_ready_i      (aw_ready_i),
    .cmd_pop_i       (cmd_pop_i),
    .start_unit_o    (start_unit),
    .start_strided_o (start_strided),
    .step_unit_o     (step_unit),
    .step_strided_o  (step_strided),
    .ar_valid_o      (ar_valid_o),
    .ar_addr_o       (ar_addr_o),
    .ar_len_o        (ar_len_o),
    .ar_size_o       (ar_size_o),
    .aw_valid_o      (aw_valid_o),
    .aw_addr_o       (aw_addr_o),
    .aw_len_o        (aw_len_o),
    .aw_size_o       (aw_size_o),
    .cmd_valid_o     (cmd_valid_o),
    .cmd_addr_o      (cmd_addr_o),
    .cmd_len_o       (cmd_len_o),
    .cmd_size_o      (cmd_size_o),
    .cmd_is_load_o   (cmd_is_load_o),
    .ack_o           (ack_o),
    .error_o         (error_o)
  );

endmodule

// ==== verification/tb_vec_addrgen.sv ====
// Directed testbench for the vector address generator
// Drives one instruction per test, records the AR, AW and command queue
// handshakes and compares them with a burst and stride model

`timescale 1ns/1ns
`include "vag_macros.svh"

module tb_vec_addrgen;

  import vag_pkg::*;

  logic      clk_i, rst_ni;
  logic      req_valid_i, req_is_load_i, req_is_unit_i;
  addr_t     req_addr_i, req_stride_i;
  vl_t       req_vl_i;
  sew_t      req_sew_i;
  logic      ar_ready_i, aw_ready_i, cmd_pop_i;
  logic      ar_valid_o, aw_valid_o, cmd_valid_o, cmd_is_load_o, ack_o, error_o;
  addr_t     ar_addr_o, aw_addr_o, cmd_addr_o;
  axi_len_t  ar_len_o, aw_len_o, cmd_len_o;
  axi_size_t ar_size_o, aw_size_o, cmd_size_o;

  integer seed = 49393;
  logic   ready_rand = 1'b0;
  logic   valid_seen;
  logic   err;

  // Expected requests and the recorded AX and cmd handshakes
  logic [31:0] exp_addr[$], got_addr[$], cmd_addr_q[$];
  logic [7:0]  exp_len[$], got_len[$], cmd_len_q[$];
  logic [2:0]  exp_size[$], got_size[$], cmd_size_q[$];
  logic        exp_load[$], got_load[$], cmd_load_q[$];

  vec_addrgen i_vec_addrgen (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Ready driver that may stall at random
  initial begin
    integer rnd;
    ar_ready_i = 1'b1;
    aw_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #2;
      if (ready_rand) begin
        rnd = $random(seed);
        ar_ready_i = rnd[0] | rnd[1];
        aw_ready_i = rnd[2] | rnd[3];
      end else begin
        ar_ready_i = 1'b1;
        aw_ready_i = 1'b1;
      end
    end
  end

  // Handshakes are sampled mid-cycle where all signals are settled
  always @(negedge clk_i) begin
    if (ar_valid_o || aw_valid_o) valid_seen = 1'b1;
    if (ar_valid_o && ar_ready_i) begin
      got_addr.push_back(ar_addr_o);
      got_len.push_back(ar_len_o);
      got_size.push_back(ar_size_o);
      got_load.push_back(1'b1);
    end
    if (aw_valid_o && aw_ready_i) begin
      got_addr.push_back(aw_addr_o);
      got_len.push_back(aw_len_o);
      got_size.push_back(aw_size_o);
      got_load.push_back(1'b0);
    end
    if (cmd_valid_o && cmd_pop_i) begin
      cmd_addr_q.push_back(cmd_addr_o);
      cmd_len_q.push_back(cmd_len_o);
      cmd_size_q.push_back(cmd_size_o);
      cmd_load_q.push_back(cmd_is_load_o);
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp));
    end
  endtask

  task automatic clear_records();
    exp_addr.delete();
    exp_len.delete();
    exp_size.delete();
    exp_load.delete();
    got_addr.delete();
    got_len.delete();
    got_size.delete();
    got_load.delete();
    cmd_addr_q.delete();
    cmd_len_q.delete();
    cmd_size_q.delete();
    cmd_load_q.delete();
    valid_seen = 1'b0;
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Bursts end at the data end, the 256-beat cap or the page end
  task automatic expect_unit(input logic [31:0] addr, input int vl, input int sew,
                             input logic is_load);
    longint unsigned a, left, first, e_data, e_cap, e_page, e_end;
    a = addr;
    left = longint'(vl) << sew;
    while (left > 0) begin
      first  = a & ~64'(`VAG_BUS_BYTES - 1);
      e_data = (a + left - 1) | 64'(`VAG_BUS_BYTES - 1);
      e_cap  = first + `VAG_MAX_BEATS * `VAG_BUS_BYTES - 1;
      e_page = a | 64'((1 << `VAG_PAGE_BITS) - 1);
      e_end  = e_data;
      if (e_cap < e_end) e_end = e_cap;
      if (e_page < e_end) e_end = e_page;
      exp_addr.push_back(a[31:0]);
      exp_len.push_back(8'((e_end - first) >> `VAG_BUS_BYTES_LOG));
      exp_size.push_back(3'(`VAG_BUS_BYTES_LOG));
      exp_load.push_back(is_load);
      if (e_end - a + 1 >= left) begin
        left = 0;
      end else begin
        left = left - (e_end - a + 1);
        a = e_end + 1;
      end
    end
  endtask

  task automatic expect_strided(input logic [31:0] addr, input int vl, input logic [31:0] stride,
                                input int sew, input logic is_load);
    logic [31:0] a;
    a = addr;
    for (int i = 0; i < vl; i++) begin
      exp_addr.push_back(a);
      exp_len.push_back(8'h0);
      exp_size.push_back(3'(sew));
      exp_load.push_back(is_load);
      a = a + stride;
    end
  endtask

  ////////////////////
  // Driving and waiting
  ////////////////////

  task automatic drive_instr(input logic [31:0] addr, input int vl, input logic [31:0] stride,
                             input int sew, input logic is_load, input logic is_unit);
    @(posedge clk_i);
    #2;
    req_valid_i   = 1'b1;
    req_addr_i    = addr;
    req_vl_i      = vl_t'(vl);
    req_stride_i  = stride;
    req_sew_i     = sew_t'(sew);
    req_is_load_i = is_load;
    req_is_unit_i = is_unit;
  endtask

  // Holds the request until ack_o, then releases it
  task automatic wait_for_ack(input int max_cycles, output logic error_seen);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      if (ack_o) begin
        seen = 1'b1;
        error_seen = error_o;
      end else begin
        n++;
        if (n > max_cycles) fail_run($sformatf("No acknowledge within %0d cycles", max_cycles));
      end
    end
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    @(negedge clk_i);
    check_val("ack_o", ack_o, 1'b0);
  endtask

  task automatic wait_cmd_drain(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk_i);
    while (cmd_valid_o) begin
      n++;
      if (n > max_cycles) fail_run("Command queue did not drain in time");
      @(negedge clk_i);
    end
  endtask

  task automatic compare_records();
    check_val("request count", got_addr.size(), exp_addr.size());
    check_val("cmd count", cmd_addr_q.size(), exp_addr.size());
    foreach (exp_addr[i]) begin
      check_val("ax is_load", got_load[i], exp_load[i]);
      check_val("ax addr", got_addr[i], exp_addr[i]);
      check_val("ax len", got_len[i], exp_len[i]);
      check_val("ax size", got_size[i], exp_size[i]);
      check_val("cmd_is_load_o", cmd_load_q[i], exp_load[i]);
      check_val("cmd_addr_o", cmd_addr_q[i], exp_addr[i]);
      check_val("cmd_len_o", cmd_len_q[i], exp_len[i]);
      check_val("cmd_size_o", cmd_size_q[i], exp_size[i]);
    end
  endtask

  task automatic run_and_compare(input logic [31:0] addr, input int vl, input logic [31:0] stride,
                                 input int sew, input logic is_load, input logic is_unit);
    drive_instr(addr, vl, stride, sew, is_load, is_unit);
    wait_for_ack(400, err);
    check_val("error_o", err, 1'b0);
    wait_cmd_drain(20);
    compare_records();
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic unit_load_short();
    clear_records();
    expect_unit(32'h104, 4, 2, 1'b1);
    run_and_compare(32'h104, 4, 0, 2, 1'b1, 1'b1);
  endtask

  task automatic store_across_page();
    clear_records();
    expect_unit(32'hFF0, 6, 3, 1'b0);
    run_and_compare(32'hFF0, 6, 0, 3, 1'b0, 1'b1);
  endtask

  task automatic long_load_stalled();
    clear_records();
    ready_rand = 1'b1;
    expect_unit(32'h0, 640, 3, 1'b1);
    run_and_compare(32'h0, 640, 0, 3, 1'b1, 1'b1);
    ready_rand = 1'b0;
  endtask

  task automatic strided_store();
    clear_records();
    expect_strided(32'h200, 3, 32'd24, 1, 1'b0);
    run_and_compare(32'h200, 3, 32'd24, 1, 1'b0, 1'b0);
  endtask

  task automatic misaligned_base();
    clear_records();
    drive_instr(32'h102, 4, 0, 2, 1'b1, 1'b1);
    wait_for_ack(20, err);
    check_val("error_o", err, 1'b1);
    check_val("ax valid seen", valid_seen, 1'b0);
  endtask

  // A queued load entry must hold back the following store
  task automatic store_waits_for_load();
    clear_records();
    expect_unit(32'h300, 1, 3, 1'b1);
    expect_unit(32'h400, 1, 3, 1'b0);
    @(posedge clk_i);
    #2;
    cmd_pop_i = 1'b0;
    drive_instr(32'h300, 1, 0, 3, 1'b1, 1'b1);
    wait_for_ack(20, err);
    check_val("cmd_valid_o", cmd_valid_o, 1'b1);
    drive_instr(32'h400, 1, 0, 3, 1'b0, 1'b1);
    repeat (6) begin
      @(negedge clk_i);
      check_val("aw_valid_o", aw_valid_o, 1'b0);
    end
    @(posedge clk_i);
    #2;
    cmd_pop_i = 1'b1;
    @(posedge clk_i);
    #2;
    cmd_pop_i = 1'b0;
    wait_for_ack(20, err);
    check_val("error_o", err, 1'b0);
    @(posedge clk_i);
    #2;
    cmd_pop_i = 1'b1;
    wait_cmd_drain(20);
    compare_records();
  endtask

  initial begin
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_vl_i      = '0;
    req_stride_i  = '0;
    req_sew_i     = '0;
    req_is_load_i = 1'b0;
    req_is_unit_i = 1'b0;
    cmd_pop_i     = 1'b1;
    valid_seen    = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("ar_valid_o", ar_valid_o, 1'b0);
    check_val("aw_valid_o", aw_valid_o, 1'b0);
    check_val("cmd_valid_o", cmd_valid_o, 1'b0);
    check_val("ack_o", ack_o, 1'b0);
    check_val("error_o", error_o, 1'b0);

    unit_load_short();
    store_across_page();
    long_load_stalled();
    strided_store();
    misaligned_base();
    store_waits_for_load();

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
source/vag_pkg.sv
source/lsu_cmd_fifo.sv
source/unit_stride_planner.sv
source/strided_planner.sv
source/ax_request_issuer.sv
source/vec_addrgen.sv
verification/tb_vec_addrgen.sv

// ==== Makefile ====
# Verilator build for the vector address generator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_vec_addrgen
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
